// ==== icache_bram.sv ====
`timescale 1ns/100ps

module icache_bram #(
    parameter int WIDTH = 21
) (
    input  logic                               clk,

    input  logic                               we_a_i,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] addr_a_i,
    input  logic [WIDTH-1:0]                   wdata_a_i,
    output logic [WIDTH-1:0]                   rdata_a_o,

    input  logic                               we_b_i,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] addr_b_i,
    input  logic [WIDTH-1:0]                   wdata_b_i,
    output logic [WIDTH-1:0]                   rdata_b_o
);
    import icache_pkg::*;

    logic [WIDTH-1:0] mem [NSET];

    // Registered read, new data on a write
    always_ff @(posedge clk) begin
        if (we_a_i) begin
            mem[addr_a_i] <= wdata_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= wdata_b_i;
        end
        rdata_a_o <= we_a_i ? wdata_a_i : mem[addr_a_i];
        rdata_b_o <= we_b_i ? wdata_b_i : mem[addr_b_i];
    end

endmodule

// ==== icache_lookup.sv ====
`timescale 1ns/100ps

module icache_lookup (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic [icache_pkg::NPORT-1:0]             rreq_i,
    input  icache_pkg::icache_addr_t [icache_pkg::NPORT-1:0] raddr_i,

    input  icache_pkg::tag_entry_t [icache_pkg::NWAY-1:0][icache_pkg::NPORT-1:0] tag_i,
    input  logic [icache_pkg::NWAY-1:0][icache_pkg::NPORT-1:0][icache_pkg::LINE_WIDTH-1:0] line_i,
    input  logic                                     busy_i,

    output icache_pkg::port_req_t [icache_pkg::NPORT-1:0] held_o,
    output logic [icache_pkg::NPORT-1:0]             hit_o,
    output logic [icache_pkg::NPORT-1:0]             rvalid_o,
    output logic [icache_pkg::NPORT-1:0][icache_pkg::LINE_WIDTH-1:0] rdata_o
);
    import icache_pkg::*;

    logic [NPORT-1:0] free;

    //////////////////////////////////////////////////
    // Tag compare and line select
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            hit_o[p]   = 1'b0;
            rdata_o[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                if (tag_i[w][p].valid && tag_i[w][p].tag == held_o[p].addr.tag) begin
                    hit_o[p]   = 1'b1;
                    rdata_o[p] = line_i[w][p];
                end
            end
            rvalid_o[p] = hit_o[p] & held_o[p].valid;
            // Blocked during the valid sweep
            free[p] = (~held_o[p].valid | rvalid_o[p]) & ~busy_i;
        end
    end

    //////////////////////////////////////////////////
    // Request registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int p = 0; p < NPORT; p++) begin
            if (free[p]) begin
                held_o[p].addr <= raddr_i[p];
            end
            if (rst) begin
                held_o[p].valid <= 1'b0;
            end else if (free[p]) begin
                held_o[p].valid <= rreq_i[p];
            end
        end
    end

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int LINE_WIDTH   = 128;
    localparam int NSET         = 256;
    localparam int NWAY         = 2;
    localparam int INDEX_WIDTH  = 8;
    localparam int OFFSET_WIDTH = 4;
    localparam int TAG_WIDTH    = 20;
    localparam int NPORT        = 2;

    // Physical fetch address
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } icache_addr_t;

    // Word held in the tag RAM
    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // Request held in a read port
    typedef struct packed {
        logic         valid;
        icache_addr_t addr;
    } port_req_t;

    // Refill or sweep write into the way array
    // A cleared tag entry invalidates every way of the index
    typedef struct packed {
        logic                   we;
        logic                   port;
        logic                   way;
        logic [INDEX_WIDTH-1:0] index;
        tag_entry_t             tag;
        logic [LINE_WIDTH-1:0]  line;
    } refill_wr_t;

    // Line request to the memory controller
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
    } mem_req_t;

endpackage

// ==== icache_refill_ctrl.sv ====
`timescale 1ns/100ps

module icache_refill_ctrl (
    input  logic                                     clk,
    input  logic                                     rst,

    input  icache_pkg::port_req_t [icache_pkg::NPORT-1:0] held_i,
    input  logic [icache_pkg::NPORT-1:0]             hit_i,

    input  logic                                     mem_rdy_i,
    input  logic                                     mem_rvalid_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0]        mem_data_i,

    output logic [icache_pkg::NPORT-1:0]             miss_o,
    output logic                                     busy_o,
    output icache_pkg::mem_req_t                     mem_req_o,
    output icache_pkg::refill_wr_t                   wr_o
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_REQ_1,
        ST_WAIT_1,
        ST_REQ_2,
        ST_WAIT_2
    } state_t;

    state_t                 state, next_state;
    logic [INDEX_WIDTH-1:0] sweep_cnt;
    logic [NPORT-1:0]       miss_pulse, miss_r;
    icache_addr_t           refill_addr;
    logic [2:0]             lfsr_q;

    //////////////////////////////////////////////////
    // Miss detect
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            miss_o[p]     = held_i[p].valid & ~hit_i[p];
            miss_pulse[p] = miss_o[p] & (state == ST_IDLE);
        end
    end

    assign busy_o = (state == ST_CLEAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_r <= '0;
        end else begin
            case (state)
                ST_IDLE: miss_r <= miss_pulse;
                ST_WAIT_1: begin
                    if (mem_rvalid_i) miss_r[0] <= 1'b0;
                end
                ST_WAIT_2: begin
                    if (mem_rvalid_i) miss_r[1] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Refill FSM
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            ST_CLEAR: begin
                if (sweep_cnt == INDEX_WIDTH'(NSET - 1)) next_state = ST_IDLE;
            end
            ST_IDLE: begin
                // Port 1 goes first
                if (miss_pulse[0]) next_state = ST_REQ_1;
                else if (miss_pulse[1]) next_state = ST_REQ_2;
            end
            ST_REQ_1: begin
                if (mem_rdy_i) next_state = ST_WAIT_1;
            end
            ST_WAIT_1: begin
                if (mem_rvalid_i) next_state = miss_r[1] ? ST_REQ_2 : ST_IDLE;
            end
            ST_REQ_2: begin
                if (mem_rdy_i) next_state = ST_WAIT_2;
            end
            ST_WAIT_2: begin
                if (mem_rvalid_i) next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_CLEAR;
            sweep_cnt <= '0;
            lfsr_q    <= 3'b001;
        end else begin
            state <= next_state;
            if (state == ST_CLEAR) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            // Free-running victim choice
            lfsr_q <= {lfsr_q[1:0], lfsr_q[2] ^ lfsr_q[1]};
        end
    end

    // Line address captured once per refill
    always_ff @(posedge clk) begin
        if (next_state == ST_REQ_1 && state != ST_REQ_1) begin
            refill_addr <= held_i[0].addr;
        end else if (next_state == ST_REQ_2 && state != ST_REQ_2) begin
            refill_addr <= held_i[1].addr;
        end
    end

    //////////////////////////////////////////////////
    // Memory request and RAM write
    //////////////////////////////////////////////////

    always_comb begin
        mem_req_o.req  = (state == ST_REQ_1) || (state == ST_REQ_2);
        mem_req_o.addr = {refill_addr.tag, refill_addr.index, {OFFSET_WIDTH{1'b0}}};
    end

    always_comb begin
        wr_o = '0;
        case (state)
            ST_CLEAR: begin
                wr_o.we    = 1'b1;
                wr_o.index = sweep_cnt;
            end
            ST_WAIT_1, ST_WAIT_2: begin
                wr_o.we        = mem_rvalid_i;
                wr_o.port      = (state == ST_WAIT_2);
                wr_o.way       = lfsr_q[0];
                wr_o.index     = refill_addr.index;
                wr_o.tag.valid = 1'b1;
                wr_o.tag.tag   = refill_addr.tag;
                wr_o.line      = mem_data_i;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/100ps

module icache_top (
    input  logic                              clk,
    input  logic                              rst,

    // Read port 1
    input  logic                              rreq_1_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_1_i,
    output logic                              rvalid_1_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_1_o,

    // Read port 2
    input  logic                              rreq_2_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_2_i,
    output logic                              rvalid_2_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_2_o,

    // Memory controller
    output icache_pkg::mem_req_t              mem_req_o,
    input  logic                              mem_rdy_i,
    input  logic                              mem_rvalid_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0] mem_data_i
);
    import icache_pkg::*;

    logic [NPORT-1:0]                          rreq;
    icache_addr_t [NPORT-1:0]                  raddr;
    port_req_t [NPORT-1:0]                     held;
    logic [NPORT-1:0]                          hit;
    logic [NPORT-1:0]                          miss;
    logic [NPORT-1:0]                          rvalid;
    logic [NPORT-1:0][LINE_WIDTH-1:0]          rdata;
    tag_entry_t [NWAY-1:0][NPORT-1:0]          tag;
    logic [NWAY-1:0][NPORT-1:0][LINE_WIDTH-1:0] line;
    refill_wr_t                                wr;
    logic                                      busy;

    assign rreq     = {rreq_2_i, rreq_1_i};
    assign raddr[0] = raddr_1_i;
    assign raddr[1] = raddr_2_i;

    assign rvalid_1_o = rvalid[0];
    assign rdata_1_o  = rdata[0];
    assign rvalid_2_o = rvalid[1];
    assign rdata_2_o  = rdata[1];

    icache_way_array u_way_array (
        .clk    (clk),
        .rreq_i (rreq),
        .raddr_i(raddr),
        .held_i (held),
        .miss_i (miss),
        .wr_i   (wr),
        .tag_o  (tag),
        .line_o (line)
    );

    icache_lookup u_lookup (
        .clk     (clk),
        .rst     (rst),
        .rreq_i  (rreq),
        .raddr_i (raddr),
        .tag_i   (tag),
        .line_i  (line),
        .busy_i  (busy),
        .held_o  (held),
        .hit_o   (hit),
        .rvalid_o(rvalid),
        .rdata_o (rdata)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk         (clk),
        .rst         (rst),
        .held_i      (held),
        .hit_i       (hit),
        .mem_rdy_i   (mem_rdy_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_data_i  (mem_data_i),
        .miss_o      (miss),
        .busy_o      (busy),
        .mem_req_o   (mem_req_o),
        .wr_o        (wr)
    );

endmodule

// ==== icache_way_array.sv ====
`timescale 1ns/100ps

module icache_way_array (
    input  logic                                     clk,

    input  logic [icache_pkg::NPORT-1:0]             rreq_i,
    input  icache_pkg::icache_addr_t [icache_pkg::NPORT-1:0] raddr_i,
    input  icache_pkg::port_req_t [icache_pkg::NPORT-1:0]    held_i,
    input  logic [icache_pkg::NPORT-1:0]             miss_i,
    input  icache_pkg::refill_wr_t                   wr_i,

    output icache_pkg::tag_entry_t [icache_pkg::NWAY-1:0][icache_pkg::NPORT-1:0] tag_o,
    output logic [icache_pkg::NWAY-1:0][icache_pkg::NPORT-1:0][icache_pkg::LINE_WIDTH-1:0] line_o
);
    import icache_pkg::*;

    logic [NPORT-1:0][INDEX_WIDTH-1:0] idx;
    logic [NWAY-1:0][NPORT-1:0]        tag_we;
    logic [NWAY-1:0][NPORT-1:0]        data_we;

    //////////////////////////////////////////////////
    // Index select
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            if (wr_i.we && wr_i.port == 1'(p)) begin
                idx[p] = wr_i.index;
            end else if (miss_i[p]) begin
                // Stalled port keeps looking up its held line
                idx[p] = held_i[p].addr.index;
            end else if (rreq_i[p]) begin
                idx[p] = raddr_i[p].index;
            end else begin
                idx[p] = '0;
            end
        end
    end

    // Write enables per way and port
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            for (int p = 0; p < NPORT; p++) begin
                tag_we[w][p] = wr_i.we && wr_i.port == 1'(p)
                               && (wr_i.way == 1'(w) || !wr_i.tag.valid);
                data_we[w][p] = wr_i.we && wr_i.port == 1'(p)
                                && wr_i.way == 1'(w) && wr_i.tag.valid;
            end
        end
    end

    //////////////////////////////////////////////////
    // RAMs, port a serves read port 1
    //////////////////////////////////////////////////

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_bram #(
            .WIDTH($bits(tag_entry_t))
        ) u_tag_ram (
            .clk      (clk),
            .we_a_i   (tag_we[w][0]),
            .addr_a_i (idx[0]),
            .wdata_a_i(wr_i.tag),
            .rdata_a_o(tag_o[w][0]),
            .we_b_i   (tag_we[w][1]),
            .addr_b_i (idx[1]),
            .wdata_b_i(wr_i.tag),
            .rdata_b_o(tag_o[w][1])
        );

        icache_bram #(
            .WIDTH(LINE_WIDTH)
        ) u_data_ram (
            .clk      (clk),
            .we_a_i   (data_we[w][0]),
            .addr_a_i (idx[0]),
            .wdata_a_i(wr_i.line),
            .rdata_a_o(line_o[w][0]),
            .we_b_i   (data_we[w][1]),
            .addr_b_i (idx[1]),
            .wdata_b_i(wr_i.line),
            .rdata_b_o(line_o[w][1])
        );
    end

endmodule

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

# Build
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_icache -o tb_icache
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run
out=$(./obj_dir/tb_icache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== sources.f ====
icache_pkg.sv
icache_bram.sv
icache_way_array.sv
icache_lookup.sv
icache_refill_ctrl.sv
icache_top.sv
tb_clkgen.sv
tb_icache.sv

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/100ps

module tb_icache;
    import icache_pkg::*;

    localparam int          TIMEOUT    = 200;
    localparam int          RAND_COUNT = 400;
    localparam int          QUIET      = 8;
    localparam logic [31:0] SEED       = 32'd87901;

    logic                            clk;
    logic                            rst;
    logic [NPORT-1:0]                rreq;
    logic [NPORT-1:0][ADDR_WIDTH-1:0] raddr;
    logic [NPORT-1:0]                rvalid;
    logic [NPORT-1:0][LINE_WIDTH-1:0] rdata;
    mem_req_t                        mem_req;
    logic                            mem_rdy;
    logic                            mem_rvalid;
    logic [LINE_WIDTH-1:0]           mem_data;

    logic [31:0] rng_state [3];
    logic [31:0] req_log [$];
    int          errors;
    int          timeouts;
    int          rdy_extra;
    logic        check_stall;
    int          stall_port;

    tb_clkgen u_clkgen (
        .clk_o(clk),
        .rst_o(rst)
    );

    icache_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .rreq_1_i    (rreq[0]),
        .raddr_1_i   (raddr[0]),
        .rvalid_1_o  (rvalid[0]),
        .rdata_1_o   (rdata[0]),
        .rreq_2_i    (rreq[1]),
        .raddr_2_i   (raddr[1]),
        .rvalid_2_o  (rvalid[1]),
        .rdata_2_o   (rdata[1]),
        .mem_req_o   (mem_req),
        .mem_rdy_i   (mem_rdy),
        .mem_rvalid_i(mem_rvalid),
        .mem_data_i  (mem_data)
    );

    //////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Streams 0 and 1 feed the ports, stream 2 the memory
    function automatic int rand_below(input int stream, input int limit);
        rng_state[stream] = xorshift32(rng_state[stream]);
        return int'(rng_state[stream] % 32'(limit));
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    // Memory content is a fixed mix of the line address
    function automatic logic [LINE_WIDTH-1:0] line_model(input logic [31:0] line_addr);
        logic [31:0]           s;
        logic [LINE_WIDTH-1:0] val;
        s = line_addr ^ 32'h6c8e_9cf5;
        for (int w = 0; w < 4; w++) begin
            s = xorshift32(s);
            val[w*32 +: 32] = s;
        end
        return val;
    endfunction

    // Three indexes, each with its own range of four tags
    function automatic logic [31:0] pool_addr(input int set_sel, input int tag_sel,
                                              input logic [3:0] offset);
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
        case (set_sel)
            0:       index = 8'h11;
            1:       index = 8'h5a;
            default: index = 8'hc3;
        endcase
        tag = 20'h0a000 + TAG_WIDTH'(set_sel * 16 + tag_sel);
        return {tag, index, offset};
    endfunction

    //////////////////////////////////////////////////
    // Checks and port driver
    //////////////////////////////////////////////////

    task automatic check_int(input string name, input int exp_val, input int act_val);
        assert (act_val == exp_val) else begin
            $display("[ERROR] %s: expected %0d actual %0d", name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_mem_req(input string name, input int pos, input logic [31:0] exp_addr);
        logic [31:0] act;
        act = 32'hffff_ffff;
        if (pos < req_log.size()) begin
            act = req_log[pos];
        end
        assert (act == exp_addr) else begin
            $display("[ERROR] %s: expected %h actual %h", name, exp_addr, act);
            errors++;
        end
    endtask

    // No line returned and no memory request while no port asks
    task automatic idle_check(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (rvalid == 2'b00 && !mem_req.req) else begin
                $display("[ERROR] %s: expected rvalid 00 req 0 actual rvalid %b req %b",
                         name, rvalid, mem_req.req);
                errors++;
            end
        end
    endtask

    // Called on a falling edge, returns on the edge that shows rvalid
    task automatic read_line(input int port, input logic [31:0] addr, input string name,
                             output int lat);
        int                    cyc;
        logic [LINE_WIDTH-1:0] exp_line;
        exp_line    = line_model(line_of(addr));
        rreq[port]  = 1'b1;
        raddr[port] = addr;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!rvalid[port] && cyc < TIMEOUT);
        assert (rvalid[port]) else begin
            $display("Port %0d returned no line within %0d cycles for address %h",
                     port + 1, TIMEOUT, addr);
            timeouts++;
        end
        if (rvalid[port]) begin
            assert (rdata[port] == exp_line) else begin
                $display("[ERROR] %s: port %0d addr %h expected %h actual %h",
                         name, port + 1, addr, exp_line, rdata[port]);
                errors++;
            end
        end
        rreq[port] = 1'b0;
        lat = cyc;
    endtask

    task automatic random_port(input int port, input int count);
        logic [31:0] addr;
        int          lat;
        for (int n = 0; n < count; n++) begin
            addr = pool_addr(rand_below(port, 3), rand_below(port, 4),
                             4'(rand_below(port, 16)));
            read_line(port, addr, "random_mix", lat);
            if (rand_below(port, 4) == 0) begin
                @(negedge clk);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Memory controller
    //////////////////////////////////////////////////

    initial begin : mem_responder
        logic [31:0] addr;
        int          rdy_wait;
        int          data_wait;
        mem_rdy    = 1'b0;
        mem_rvalid = 1'b0;
        mem_data   = '0;
        @(negedge clk);
        forever begin
            if (mem_req.req) begin
                addr     = mem_req.addr;
                rdy_wait = rand_below(2, 4) + rdy_extra;
                for (int i = 0; i < rdy_wait; i++) begin
                    @(negedge clk);
                    assert (mem_req.req && mem_req.addr == addr) else begin
                        $display("[ERROR] mem_stall: expected req 1 addr %h actual req %b addr %h",
                                 addr, mem_req.req, mem_req.addr);
                        errors++;
                    end
                    if (check_stall) begin
                        assert (!rvalid[stall_port]) else begin
                            $display("[ERROR] mem_stall: expected rvalid 0 actual %b",
                                     rvalid[stall_port]);
                            errors++;
                        end
                    end
                end
                mem_rdy = 1'b1;
                @(negedge clk);
                mem_rdy = 1'b0;
                req_log.push_back(addr);
                data_wait = rand_below(2, 5) + 1;
                repeat (data_wait - 1) @(negedge clk);
                mem_rvalid = 1'b1;
                mem_data   = line_model(addr);
                @(negedge clk);
                mem_rvalid = 1'b0;
                mem_data   = '0;
            end else begin
                @(negedge clk);
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : main
        int          lat;
        int          lat2;
        int          base;
        int          cyc;
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        rreq         = '0;
        raddr        = '0;
        errors       = 0;
        timeouts     = 0;
        rdy_extra    = 0;
        check_stall  = 1'b0;
        stall_port   = 0;
        rng_state[0] = SEED;
        rng_state[1] = SEED ^ 32'h9e37_79b9;
        rng_state[2] = SEED ^ 32'h7f4a_7c15;

        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (rst && cyc < TIMEOUT);
        assert (!rst) else begin
            $display("Reset was never released");
            timeouts++;
        end

        // Quiet through the valid sweep, then one fetch per new line
        idle_check("reset_idle", NSET + 16);
        addr_a = pool_addr(0, 0, 4'h4);
        base   = req_log.size();
        read_line(0, addr_a, "first_miss", lat);
        check_int("first_miss_reqs", base + 1, req_log.size());
        check_mem_req("first_miss_addr", base, line_of(addr_a));

        base = req_log.size();
        read_line(0, pool_addr(0, 0, 4'hc), "rehit", lat);
        check_int("rehit_latency", 1, lat);
        idle_check("rehit_idle", QUIET);
        check_int("rehit_reqs", base, req_log.size());

        // Three tags fighting over two ways
        for (int t = 1; t < 3; t++) begin
            read_line(0, pool_addr(0, t, 4'(t * 5)), "conflict", lat);
        end
        for (int t = 0; t < 3; t++) begin
            read_line(0, pool_addr(0, t, 4'(t * 3)), "conflict", lat);
        end

        addr_a = pool_addr(1, 0, 4'h3);
        addr_b = pool_addr(2, 0, 4'h7);
        base   = req_log.size();
        fork
            read_line(0, addr_a, "dual_miss_1", lat);
            read_line(1, addr_b, "dual_miss_2", lat2);
        join
        check_int("dual_miss_reqs", base + 2, req_log.size());
        check_mem_req("dual_miss_first", base, line_of(addr_a));
        check_mem_req("dual_miss_second", base + 1, line_of(addr_b));

        // Memory holds off the handshake for a while
        rdy_extra   = 12;
        stall_port  = 1;
        check_stall = 1'b1;
        read_line(1, pool_addr(1, 1, 4'h0), "mem_stall", lat);
        check_stall = 1'b0;
        rdy_extra   = 0;
        assert (lat > 12) else begin
            $display("[ERROR] mem_stall_latency: expected above 12 actual %0d", lat);
            errors++;
        end
        base = req_log.size();
        read_line(1, pool_addr(1, 1, 4'h9), "rehit_port2", lat);
        check_int("rehit_port2_latency", 1, lat);
        idle_check("rehit_port2_idle", QUIET);
        check_int("rehit_port2_reqs", base, req_log.size());

        fork
            random_port(0, RAND_COUNT);
            random_port(1, RAND_COUNT);
        join

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
